/* src/dmr_params.svh */
`ifndef DMR_PARAMS_SVH
`define DMR_PARAMS_SVH

// --------------------------------------------------
// replica fan-out
// --------------------------------------------------

// number of lockstep replicas that receive the interrupt and return an ack
// the default pair is plain DMR, 3 also works for a triple of replicas
`define DMR_NUM_REPLICAS 2

// --------------------------------------------------
// delivery retries
// --------------------------------------------------

// replays allowed after a failed first attempt before the error is latched
`define DMR_MAX_RETRY 3

// width of the retry counter, it has to hold DMR_MAX_RETRY itself
`define DMR_RETRY_CNT_W 2

`endif

/* src/irq_pkg.sv */
`include "dmr_params.svh"

// types for the interrupt path between the source, the fork and the replicas
package irq_pkg;

  // --------------------------------------------------
  // per-replica vectors
  // --------------------------------------------------

  // one bit per replica, bit i belongs to replica i
  // the same shape carries the forked interrupt lines and the acks
  // that come back from the replicas
  typedef logic [`DMR_NUM_REPLICAS-1:0] irq_vec_t;

  // a replica acks in the same cycle that it sees its interrupt bit high,
  // so an ack vector is only ever a subset of the irq vector of that cycle
  // all ones in the ack vector is a clean delivery to every replica
  // a partial pattern means the replicas saw different things
  // an all zero pattern with an active interrupt is a silent miss

endpackage

/* src/recovery_pkg.sv */
`include "dmr_params.svh"

// types for the delivery monitor and its replay bookkeeping
package recovery_pkg;

  // --------------------------------------------------
  // monitor FSM
  // --------------------------------------------------

  // MON_IDLE means no failed attempt is pending
  // MON_RETRY means a replay is in flight in the fork
  // MON_FATAL is sticky until reset, the retries ran out
  // the fourth code is unused and the monitor treats it as fatal
  typedef enum logic [1:0] {
    MON_IDLE  = 2'd0,
    MON_RETRY = 2'd1,
    MON_FATAL = 2'd2
  } mon_state_e;

  // --------------------------------------------------
  // retry accounting
  // --------------------------------------------------

  // counts the replays spent on the current interrupt
  // cleared by a successful delivery, saturates at DMR_MAX_RETRY
  typedef logic [`DMR_RETRY_CNT_W-1:0] retry_cnt_t;

endpackage

/* src/tmr_state_reg.sv */
// triplicated register for FSM state
// three copies are written with the same next value and read through
// a bitwise majority vote, so one flipped copy never reaches q_o
module tmr_state_reg #(
  parameter int WIDTH = 4
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [WIDTH-1:0] d_i,
  output logic [WIDTH-1:0] q_o,
  output logic             mismatch_o
);

  // --------------------------------------------------
  // storage
  // --------------------------------------------------

  // the three copies, kept as separate vectors so each one is its own flop set
  logic [WIDTH-1:0] copy_a_q;
  logic [WIDTH-1:0] copy_b_q;
  logic [WIDTH-1:0] copy_c_q;

  // every copy loads the same next value on each clock
  // the user computes d_i from the voted q_o, so a copy hit by an upset
  // is overwritten with the majority value on the following edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      copy_a_q <= '0;
      copy_b_q <= '0;
      copy_c_q <= '0;
    end else begin
      copy_a_q <= d_i;
      copy_b_q <= d_i;
      copy_c_q <= d_i;
    end
  end

  // --------------------------------------------------
  // voting
  // --------------------------------------------------

  // bitwise two-out-of-three majority
  // each bit is voted on its own, so upsets in different bits of
  // different copies are still masked
  assign q_o = (copy_a_q & copy_b_q) |
               (copy_a_q & copy_c_q) |
               (copy_b_q & copy_c_q);

  // any copy that differs from another one in any bit
  // comparing a against b and a against c covers every disagreement,
  // since b and c can only differ if one of them differs from a
  assign mismatch_o = (|(copy_a_q ^ copy_b_q)) |
                      (|(copy_a_q ^ copy_c_q));

endmodule

/* src/dmr_interrupt_fork.sv */
`include "dmr_params.svh"

// fans one interrupt source out to every replica
// the interrupt is forwarded combinationally, and when repeat_i is high in
// a cycle with an active interrupt, every output is raised again one cycle
// later
// only one replay can be outstanding at a time, the source is expected to
// stay quiet while it is in flight
module dmr_interrupt_fork (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              repeat_i,
  input  logic              irq_i,
  output irq_pkg::irq_vec_t irq_o
);

  // --------------------------------------------------
  // outstanding replay, triplicated
  // --------------------------------------------------

  // three copies of the "replay next cycle" bit
  logic [2:0] outstanding_d;
  logic [2:0] outstanding_q;

  // voted replay used inside the fork for the next-state decision
  logic replay_int;

  // interrupt seen by the replicas in this cycle, fresh or replayed
  logic irq_active;

  // one voted replay bit per output
  irq_pkg::irq_vec_t replay_voted;

  // internal majority of the three copies
  assign replay_int = (outstanding_q[0] & outstanding_q[1]) |
                      (outstanding_q[0] & outstanding_q[2]) |
                      (outstanding_q[1] & outstanding_q[2]);

  assign irq_active = irq_i | replay_int;

  // a replay is armed only when the request meets an active interrupt
  // a replayed cycle can itself be replayed, which is how the monitor
  // chains several retries back to back
  // all copies take the voted value, so a single upset is repaired
  assign outstanding_d = {3{repeat_i & irq_active}};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= '0;
    end else begin
      outstanding_q <= outstanding_d;
    end
  end

  // --------------------------------------------------
  // outputs
  // --------------------------------------------------

  // each output has its own voter, so a glitch in one voter cannot raise
  // or drop the interrupt on every replica at the same time
  for (genvar i = 0; i < `DMR_NUM_REPLICAS; i++) begin : gen_out_voter
    assign replay_voted[i] = (outstanding_q[0] & outstanding_q[1]) |
                             (outstanding_q[0] & outstanding_q[2]) |
                             (outstanding_q[1] & outstanding_q[2]);
  end

  // fresh interrupt goes straight through in the same cycle
  assign irq_o = {`DMR_NUM_REPLICAS{irq_i}} | replay_voted;

  // --------------------------------------------------
  // source handshake
  // --------------------------------------------------

  // once a replay has been armed the next cycle belongs to it
  // a new source pulse there would be merged into the replay and lost
  irq_overrun_chk : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (repeat_i && irq_active) |=> !irq_i
  ) else $warning("interrupt overrun while a replay is outstanding");

endmodule

/* src/irq_delivery_monitor.sv */
`include "dmr_params.svh"

// watches the acks that the replicas return for each interrupt attempt
// a failed attempt asks the fork for a replay until the retries run out,
// after which a fatal error is latched until reset
// the FSM state and the retry counter live in one triplicated register
module irq_delivery_monitor (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  irq_pkg::irq_vec_t irq_i,
  input  irq_pkg::irq_vec_t ack_i,
  output logic              repeat_o,
  output logic              delivered_o,
  output logic              diverge_o,
  output logic              fatal_o
);

  // widths of the fields packed into the protected register
  localparam int STATE_W = $bits(recovery_pkg::mon_state_e);
  localparam int CNT_W   = `DMR_RETRY_CNT_W;
  localparam int REG_W   = STATE_W + CNT_W;

  // --------------------------------------------------
  // attempt classification
  // --------------------------------------------------

  logic irq_active;
  logic all_ack;
  logic acks_equal;
  logic attempt_ok;
  logic attempt_fail;
  logic retries_left;

  // any replica output high counts as an attempt, fresh or replayed
  assign irq_active = |irq_i;

  // success needs every replica to have taken it
  assign all_ack = &ack_i;

  // the acks agree when they are all ones or all zeros
  // a failed attempt with disagreeing acks means the replicas diverged
  assign acks_equal = (&ack_i) | ~(|ack_i);

  assign attempt_ok   = irq_active & all_ack;
  assign attempt_fail = irq_active & ~all_ack;

  // --------------------------------------------------
  // protected state
  // --------------------------------------------------

  recovery_pkg::mon_state_e state_d;
  recovery_pkg::mon_state_e state_q;
  recovery_pkg::retry_cnt_t cnt_d;
  recovery_pkg::retry_cnt_t cnt_q;
  logic [REG_W-1:0]         reg_d;
  logic [REG_W-1:0]         reg_q;

  assign reg_d = {state_d, cnt_d};

  tmr_state_reg #(
    .WIDTH (REG_W)
  ) i_state_reg (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .d_i        (reg_d),
    .q_o        (reg_q),
    .mismatch_o ()
  );

  // unpack the voted value, all zeros after reset is MON_IDLE with no retries
  assign state_q = recovery_pkg::mon_state_e'(reg_q[REG_W-1 -: STATE_W]);
  assign cnt_q   = reg_q[CNT_W-1:0];

  // retries remain while not fatal and the counter is below the limit
  assign retries_left = (state_q != recovery_pkg::MON_FATAL) &&
                        (cnt_q < recovery_pkg::retry_cnt_t'(`DMR_MAX_RETRY));

  // replay request goes to the fork in the same cycle as the failed attempt
  assign repeat_o = attempt_fail & retries_left;

  // --------------------------------------------------
  // next state
  // --------------------------------------------------

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    case (state_q)
      recovery_pkg::MON_IDLE, recovery_pkg::MON_RETRY: begin
        if (attempt_ok) begin
          // delivered to every replica, start fresh for the next interrupt
          state_d = recovery_pkg::MON_IDLE;
          cnt_d   = '0;
        end else if (attempt_fail) begin
          if (retries_left) begin
            state_d = recovery_pkg::MON_RETRY;
            cnt_d   = cnt_q + recovery_pkg::retry_cnt_t'(1);
          end else begin
            // last replay failed too
            state_d = recovery_pkg::MON_FATAL;
          end
        end
      end
      recovery_pkg::MON_FATAL: begin
        // sticky, only reset leaves this state
        state_d = recovery_pkg::MON_FATAL;
      end
      default: begin
        // the unused code can only come from several upsets at once
        state_d = recovery_pkg::MON_FATAL;
      end
    endcase
  end

  // --------------------------------------------------
  // status outputs
  // --------------------------------------------------

  // delivered and diverge are single-cycle pulses one cycle after the attempt
  // a success after the error is latched is not reported as a delivery
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      delivered_o <= 1'b0;
      diverge_o   <= 1'b0;
    end else begin
      delivered_o <= attempt_ok & (state_q != recovery_pkg::MON_FATAL);
      diverge_o   <= attempt_fail & ~acks_equal;
    end
  end

  // fatal follows the voted state, so it already lags the attempt by a cycle
  assign fatal_o = (state_q == recovery_pkg::MON_FATAL);

  // --------------------------------------------------
  // checks
  // --------------------------------------------------

  // a replica may only ack the interrupt line the fork is driving to it
  ack_without_irq_chk : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (ack_i & ~irq_i) == '0
  ) else $error("replica ack without an active interrupt line");

  // a latched error and a delivery report exclude each other
  delivered_fatal_chk : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(delivered_o && fatal_o)
  ) else $error("delivered and fatal reported together");

endmodule

/* src/dmr_irq_subsystem.sv */
// top level of the interrupt delivery path for a pair of lockstep replicas
// the fork drives the replicas, the monitor checks their acks and asks
// the fork for replays through repeat
module dmr_irq_subsystem (
  input  logic              clk_i,
  input  logic              rst_ni,
  // single-cycle interrupt from the source
  input  logic              irq_i,
  // one ack per replica, same cycle as its interrupt line
  input  irq_pkg::irq_vec_t ack_i,
  // forked interrupt to the replicas
  output irq_pkg::irq_vec_t irq_o,
  // status, pulses for delivered and diverge, level for fatal
  output logic              delivered_o,
  output logic              diverge_o,
  output logic              fatal_o
);

  // --------------------------------------------------
  // internal wiring
  // --------------------------------------------------

  // replay request from the monitor into the fork
  // this is the only signal that goes from monitor to fork
  logic irq_repeat;

  // --------------------------------------------------
  // fork
  // --------------------------------------------------

  // first attempt shows up in the cycle of irq_i
  // a replay shows up one cycle after a requested repeat
  dmr_interrupt_fork i_fork (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .repeat_i (irq_repeat),
    .irq_i    (irq_i),
    .irq_o    (irq_o)
  );

  // --------------------------------------------------
  // monitor
  // --------------------------------------------------

  // the monitor sees the same vector the replicas see
  // a persistently failing interrupt keeps irq_o high for
  // 1 + DMR_MAX_RETRY cycles before fatal is latched
  irq_delivery_monitor i_monitor (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .irq_i       (irq_o),
    .ack_i       (ack_i),
    .repeat_o    (irq_repeat),
    .delivered_o (delivered_o),
    .diverge_o   (diverge_o),
    .fatal_o     (fatal_o)
  );

endmodule

/* tests/tb_dmr_irq_subsystem.sv */
`include "dmr_params.svh"

module tb_dmr_irq_subsystem;

  localparam int CLK_PERIOD = 8;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_RANDOM = 40;
  // worst case per interrupt is the full retry chain, one idle cycle and a short reset
  localparam int PULSE_CYCLES = `DMR_MAX_RETRY + 6;
  localparam int TOTAL_CYCLES = 2 * RESET_CYCLES + (NUM_RANDOM + 8) * PULSE_CYCLES;
  localparam int WATCHDOG_CYCLES = TOTAL_CYCLES + 200;
  localparam irq_pkg::irq_vec_t ALL_ONES = '1;

  logic              clk_i;
  logic              rst_ni;
  logic              irq_i;
  irq_pkg::irq_vec_t ack_i;
  irq_pkg::irq_vec_t irq_o;
  logic              delivered_o;
  logic              diverge_o;
  logic              fatal_o;

  integer seed;
  int     test_errors;
  int     tests_passed;
  int     tests_failed;

  // reference model of the fork and the monitor
  logic m_replay;
  int   m_cnt;
  logic m_fatal;
  logic m_delivered;
  logic m_diverge;

  // observed events within the current test
  int obs_irq_cycles;
  int obs_delivered;
  int obs_diverge;

  dmr_irq_subsystem dut_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .irq_i       (irq_i),
    .ack_i       (ack_i),
    .irq_o       (irq_o),
    .delivered_o (delivered_o),
    .diverge_o   (diverge_o),
    .fatal_o     (fatal_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // --------------------------------------------------
  // checking and bookkeeping
  // --------------------------------------------------

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %0h, expected %0h", $time, what, got, exp);
      test_errors++;
    end
  endtask

  task automatic start_test();
    test_errors = 0;
    obs_irq_cycles = 0;
    obs_delivered = 0;
    obs_diverge = 0;
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0) begin
      tests_passed++;
      $display("%s: pass", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, test_errors);
    end
  endtask

  task automatic model_reset();
    m_replay = 1'b0;
    m_cnt = 0;
    m_fatal = 1'b0;
    m_delivered = 1'b0;
    m_diverge = 1'b0;
  endtask

  // holds reset low over the given number of rising edges
  // entered and left one time unit after a rising edge
  task automatic apply_reset(input int cycles);
    rst_ni = 1'b0;
    irq_i = 1'b0;
    ack_i = '0;
    repeat (cycles) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    model_reset();
  endtask

  // --------------------------------------------------
  // one clock cycle against the reference model
  // --------------------------------------------------

  // a replica can only ack a line that is high, so the acks are masked
  // with the interrupt the model expects in this cycle
  task automatic step(input logic irq, input irq_pkg::irq_vec_t ack);
    logic              active;
    logic              all_ack;
    logic              fail;
    logic              rep;
    irq_pkg::irq_vec_t ack_d;
    active = irq | m_replay;
    ack_d = active ? ack : '0;
    irq_i = irq;
    ack_i = ack_d;
    // outputs are settled well before the next edge
    #2;
    check_value("irq_o", irq_o, active ? ALL_ONES : '0);
    check_value("delivered_o", delivered_o, m_delivered);
    check_value("diverge_o", diverge_o, m_diverge);
    check_value("fatal_o", fatal_o, m_fatal);
    if (irq_o != '0) obs_irq_cycles++;
    if (delivered_o) obs_delivered++;
    if (diverge_o) obs_diverge++;
    // next state from the handshake and retry rules
    all_ack = &ack_d;
    fail = active & ~all_ack;
    rep = fail & ~m_fatal & (m_cnt < `DMR_MAX_RETRY);
    // a delivery is never reported together with a latched error
    m_delivered = active & all_ack & ~m_fatal;
    // diverging acks have some bits set but not all of them
    m_diverge = fail & (ack_d != '0);
    if (active && all_ack && !m_fatal) begin
      m_cnt = 0;
    end else if (rep) begin
      m_cnt++;
    end else if (fail) begin
      m_fatal = 1'b1;
    end
    m_replay = rep;
    @(posedge clk_i);
    #1;
  endtask

  // one source pulse, followed through its replays and one idle cycle
  task automatic deliver_interrupt(input irq_pkg::irq_vec_t first_ack,
                                   input irq_pkg::irq_vec_t replay_ack,
                                   input bit random_ack);
    int          guard;
    logic [31:0] rnd;
    rnd = $random(seed);
    step(1'b1, random_ack ? rnd[`DMR_NUM_REPLICAS-1:0] : first_ack);
    guard = 0;
    while (m_replay && guard < `DMR_MAX_RETRY + 2) begin
      rnd = $random(seed);
      step(1'b0, random_ack ? rnd[`DMR_NUM_REPLICAS-1:0] : replay_ack);
      guard++;
    end
    if (m_replay) begin
      $display("replay chain did not end within the retry limit at %0t", $time);
      test_errors++;
    end
    // the idle cycle carries the status pulses of the last attempt
    step(1'b0, '0);
  endtask

  // --------------------------------------------------
  // directed tests
  // --------------------------------------------------

  task automatic test_clean_delivery();
    start_test();
    deliver_interrupt(ALL_ONES, ALL_ONES, 1'b0);
    check_value("irq_o active cycles", obs_irq_cycles, 1);
    check_value("delivered_o pulses", obs_delivered, 1);
    check_value("diverge_o pulses", obs_diverge, 0);
    finish_test("clean_delivery");
  endtask

  task automatic test_divergent_retry();
    irq_pkg::irq_vec_t only_first;
    only_first = '0;
    only_first[0] = 1'b1;
    start_test();
    deliver_interrupt(only_first, ALL_ONES, 1'b0);
    check_value("irq_o active cycles", obs_irq_cycles, 2);
    check_value("diverge_o pulses", obs_diverge, 1);
    check_value("delivered_o pulses", obs_delivered, 1);
    finish_test("divergent_retry");
  endtask

  task automatic test_retry_exhaustion();
    start_test();
    deliver_interrupt('0, '0, 1'b0);
    check_value("irq_o active cycles", obs_irq_cycles, 1 + `DMR_MAX_RETRY);
    check_value("fatal_o after retries", fatal_o, 1'b1);
    // later interrupts pass through once each, never replayed
    obs_irq_cycles = 0;
    deliver_interrupt('0, '0, 1'b0);
    deliver_interrupt('0, '0, 1'b0);
    check_value("irq_o cycles while fatal", obs_irq_cycles, 2);
    check_value("fatal_o sticky", fatal_o, 1'b1);
    finish_test("retry_exhaustion");
  endtask

  task automatic test_reset_recovery();
    start_test();
    check_value("fatal_o before reset", fatal_o, 1'b1);
    apply_reset(RESET_CYCLES);
    check_value("irq_o after reset", irq_o, '0);
    check_value("delivered_o after reset", delivered_o, 1'b0);
    check_value("diverge_o after reset", diverge_o, 1'b0);
    check_value("fatal_o after reset", fatal_o, 1'b0);
    deliver_interrupt(ALL_ONES, ALL_ONES, 1'b0);
    check_value("delivered_o pulses", obs_delivered, 1);
    finish_test("reset_recovery");
  endtask

  // random acks on every attempt, the model checks each cycle
  // a latched error is cleared with a short reset so later pulses still retry
  task automatic test_random_acks();
    start_test();
    for (int n = 0; n < NUM_RANDOM; n++) begin
      deliver_interrupt('0, '0, 1'b1);
      if (m_fatal) apply_reset(2);
    end
    finish_test("random_acks");
  endtask

  // --------------------------------------------------
  // sequence and watchdog
  // --------------------------------------------------

  initial begin
    seed = 32'h1ab85944;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    irq_i = 1'b0;
    ack_i = '0;
    tests_passed = 0;
    tests_failed = 0;
    test_errors = 0;
    model_reset();
    apply_reset(RESET_CYCLES);
    test_clean_delivery();
    test_divergent_retry();
    test_retry_exhaustion();
    test_reset_recovery();
    test_random_acks();
    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* tb.f */
+incdir+src
src/irq_pkg.sv
src/recovery_pkg.sv
src/tmr_state_reg.sv
src/dmr_interrupt_fork.sv
src/irq_delivery_monitor.sv
src/dmr_irq_subsystem.sv
tests/tb_dmr_irq_subsystem.sv
